// ==== list.f ====
mutative_pkg.sv
mutative_fsm.sv
mutative_plru.sv
mutative_cache.sv
mutative_cfg_apb.sv
mutative_top.sv
tb_checker.sv
tb_top.sv

// ==== mutative_cache.sv ====
`default_nettype none

module mutative_cache #(
    parameter int WAYS = mutative_pkg::WAYS,
    parameter int SETS = mutative_pkg::SETS
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [31:0]                        ufp_addr,
    input  wire  [3:0]                         ufp_rmask,
    input  wire  [3:0]                         ufp_wmask,
    input  wire  [31:0]                        ufp_wdata,
    output logic [31:0]                        ufp_rdata,
    output logic                               ufp_resp,
    output logic [31:0]                        dfp_addr,
    output logic                               dfp_read,
    output logic                               dfp_write,
    output logic [mutative_pkg::LINE_BITS-1:0] dfp_wdata,
    input  wire  [mutative_pkg::LINE_BITS-1:0] dfp_rdata,
    input  wire                                dfp_resp,
    input  wire  mutative_pkg::setup_t         setup,
    input  wire                                flush_req,
    output logic                               flush_done,
    output logic                               hit_pulse,
    output logic                               miss_pulse
);
    import mutative_pkg::*;

    logic [31:0]             addr_q;        // latched request
    logic [3:0]              wmask_q;
    logic [31:0]             wdata_q;
    logic [TAG_BITS-1:0]     tag_arr   [SETS][WAYS];
    logic [LINE_BITS-1:0]    data_arr  [SETS][WAYS];
    logic [WAYS-1:0]         valid_arr [SETS];
    logic [WAYS-1:0]         dirty_arr [SETS];
    logic [TAG_BITS-1:0]     rd_tag    [WAYS];  // synchronous read out
    logic [LINE_BITS-1:0]    rd_data   [WAYS];
    logic [TAG_BITS-1:0]     req_tag;
    logic [SET_BITS-1:0]     req_set;
    logic [SET_BITS-1:0]     sel_set;
    logic [SET_BITS-1:0]     rd_set;
    logic [1:0]              word_sel;
    logic [WAY_IDX_BITS-1:0] sel_way;
    logic [WAY_IDX_BITS-1:0] hit_way;
    logic [WAY_IDX_BITS-1:0] victim_way;
    logic [WAYS-1:0]         way_en;
    logic [WAYS-1:0]         hit_vec;
    logic [WAYS-1:0]         way_we;
    logic [LINE_BITS-1:0]    line_wdata;
    logic [4:0]              flush_idx;     // {set, way}
    logic                    hit;
    logic                    idle;
    logic                    flushing;
    logic                    write_from_mem;
    logic                    write_from_cpu;
    logic                    cpu_we;

    assign req_tag  = addr_q[31 -: TAG_BITS];
    assign req_set  = addr_q[OFFSET_BITS +: SET_BITS];
    assign word_sel = addr_q[3:2];
    assign sel_set  = flushing ? flush_idx[WAY_IDX_BITS +: SET_BITS] : req_set;
    assign sel_way  = flushing ? flush_idx[WAY_IDX_BITS-1:0] : victim_way;
    assign rd_set   = idle ? ufp_addr[OFFSET_BITS +: SET_BITS] : sel_set;
    assign cpu_we   = write_from_cpu & (|wmask_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            wmask_q <= '0;
        end else if (idle) begin
            wmask_q <= ufp_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (idle) begin
            addr_q  <= ufp_addr;
            wdata_q <= ufp_wdata;
        end
    end

    // ways allowed by the current setup, then full tag compare
    always_comb begin
        case (setup)
            SETUP_DM:   way_en = WAYS'(1) << req_tag[1:0];
            SETUP_2WAY: way_en = WAYS'(3) << {req_tag[0], 1'b0};
            default:    way_en = '1;
        endcase
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = way_en[w] & valid_arr[req_set][w] & (rd_tag[w] == req_tag);
            if (hit_vec[w]) hit_way = WAY_IDX_BITS'(w);
        end
    end

    assign hit       = |hit_vec;
    assign ufp_rdata = rd_data[hit_way][32*word_sel +: 32];

    always_comb begin
        line_wdata = rd_data[hit_way];  // byte merge into hit line
        for (int b = 0; b < 4; b++) begin
            if (wmask_q[b]) line_wdata[32*word_sel + 8*b +: 8] = wdata_q[8*b +: 8];
        end
        if (write_from_mem) line_wdata = dfp_rdata;
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_we[w] = (write_from_mem && victim_way == WAY_IDX_BITS'(w))
                     || (cpu_we && hit_way == WAY_IDX_BITS'(w));
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (way_we[w]) begin
                tag_arr[req_set][w]  <= req_tag;
                data_arr[req_set][w] <= line_wdata;
            end
            rd_tag[w]  <= way_we[w] ? req_tag : tag_arr[rd_set][w];   // forward refill
            rd_data[w] <= way_we[w] ? line_wdata : data_arr[rd_set][w];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '{default: '0};
            dirty_arr <= '{default: '0};
        end else if (flushing) begin
            valid_arr[sel_set][sel_way] <= 1'b0;    // entry under flush
            dirty_arr[sel_set][sel_way] <= 1'b0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (way_we[w]) begin
                    valid_arr[req_set][w] <= 1'b1;
                    dirty_arr[req_set][w] <= cpu_we;    // refill lands clean
                end
            end
        end
    end

    assign dfp_addr  = dfp_write ? {rd_tag[sel_way], sel_set, OFFSET_BITS'(0)}
                                 : {addr_q[31:OFFSET_BITS], OFFSET_BITS'(0)};
    assign dfp_wdata = rd_data[sel_way];

    mutative_fsm #(.WAYS(WAYS), .SETS(SETS)) u_fsm (
        .clk            (clk),
        .rst            (rst),
        .cpu_req        ((|ufp_rmask) | (|ufp_wmask)),
        .hit            (hit),
        .victim_dirty   (dirty_arr[sel_set][sel_way]),
        .victim_valid   (valid_arr[sel_set][sel_way]),
        .dfp_resp       (dfp_resp),
        .flush_req      (flush_req),
        .ufp_resp       (ufp_resp),
        .dfp_read       (dfp_read),
        .dfp_write      (dfp_write),
        .write_from_mem (write_from_mem),
        .write_from_cpu (write_from_cpu),
        .idle           (idle),
        .flushing       (flushing),
        .flush_idx      (flush_idx),
        .flush_done     (flush_done),
        .hit_pulse      (hit_pulse),
        .miss_pulse     (miss_pulse)
    );

    mutative_plru #(.WAYS(WAYS), .SETS(SETS)) u_plru (
        .clk        (clk),
        .rst        (rst),
        .set_index  (req_set),
        .tag_low    (req_tag[1:0]),
        .setup      (setup),
        .access_way (write_from_mem ? victim_way : hit_way),
        .access_en  (ufp_resp | write_from_mem),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

// ==== mutative_cfg_apb.sv ====
`default_nettype none

module mutative_cfg_apb (
    input  wire                         clk,
    input  wire                         rst,
    input  wire  [3:0]                  paddr,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire  [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output mutative_pkg::setup_t        setup,
    output logic                        flush_req,
    input  wire                         flush_done,
    input  wire                         hit_pulse,
    input  wire                         miss_pulse
);
    import mutative_pkg::*;

    logic        acc_wr;        // write access phase
    setup_t      new_setup;
    logic [31:0] hits;
    logic [31:0] misses;

    assign acc_wr    = psel & penable & pwrite;
    assign new_setup = setup_t'(pwdata[1:0]);

    // a changed setup stalls the transfer until the cache is flushed
    assign flush_req = acc_wr && paddr == REG_SETUP && new_setup != setup;
    assign pready    = !flush_req || flush_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            setup  <= SETUP_4WAY;
            hits   <= '0;
            misses <= '0;
        end else begin
            if (flush_req && flush_done) setup <= new_setup;
            if (acc_wr && paddr == REG_HITS) begin
                hits <= '0;
            end else if (hit_pulse && hits != '1) begin
                hits <= hits + 32'd1;                   // saturates
            end
            if (acc_wr && paddr == REG_MISSES) begin
                misses <= '0;
            end else if (miss_pulse && misses != '1) begin
                misses <= misses + 32'd1;
            end
        end
    end

    always_comb begin
        case (paddr)
            REG_SETUP:  prdata = {30'd0, setup};
            REG_HITS:   prdata = hits;
            REG_MISSES: prdata = misses;
            default:    prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== mutative_fsm.sv ====
`default_nettype none

module mutative_fsm #(
    parameter int WAYS = mutative_pkg::WAYS,
    parameter int SETS = mutative_pkg::SETS
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        cpu_req,
    input  wire        hit,
    input  wire        victim_dirty,
    input  wire        victim_valid,
    input  wire        dfp_resp,
    input  wire        flush_req,
    output logic       ufp_resp,
    output logic       dfp_read,
    output logic       dfp_write,
    output logic       write_from_mem,
    output logic       write_from_cpu,
    output logic       idle,
    output logic       flushing,
    output logic [4:0] flush_idx,
    output logic       flush_done,
    output logic       hit_pulse,
    output logic       miss_pulse
);
    import mutative_pkg::*;

    localparam logic [4:0] LAST_IDX = 5'(WAYS * SETS - 1);

    cache_state_t state;
    cache_state_t next_state;
    logic         refill;       // compare right after an allocate
    logic         wb_needed;
    logic         last_entry;

    assign wb_needed  = victim_valid & victim_dirty;
    assign last_entry = flush_idx == LAST_IDX;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            flush_idx <= '0;
            refill    <= 1'b0;
        end else begin
            state  <= next_state;
            refill <= state == ST_ALLOCATE;
            if (state == ST_FLUSH && !wb_needed) begin
                flush_idx <= last_entry ? '0 : flush_idx + 5'd1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (flush_req) next_state = ST_FLUSH;     // setup change wins
                else if (cpu_req) next_state = ST_COMPARE;
            end
            ST_COMPARE: begin
                if (hit) next_state = ST_IDLE;
                else if (wb_needed) next_state = ST_WRITEBACK;
                else next_state = ST_ALLOCATE;
            end
            ST_WRITEBACK: if (dfp_resp) next_state = ST_ALLOCATE;
            ST_ALLOCATE:  if (dfp_resp) next_state = ST_COMPARE;
            ST_FLUSH: begin
                if (wb_needed) next_state = ST_FLUSH_WB;
                else if (last_entry) next_state = ST_IDLE;
            end
            ST_FLUSH_WB:  if (dfp_resp) next_state = ST_FLUSH;
            default:      next_state = ST_IDLE;
        endcase
    end

    assign idle           = state == ST_IDLE;
    assign flushing       = state == ST_FLUSH || state == ST_FLUSH_WB;
    assign ufp_resp       = state == ST_COMPARE && hit;
    assign write_from_cpu = ufp_resp;                       // cache applies it on writes
    assign hit_pulse      = ufp_resp && !refill;
    assign miss_pulse     = state == ST_COMPARE && !hit;
    assign dfp_write      = state == ST_WRITEBACK || state == ST_FLUSH_WB;
    assign dfp_read       = state == ST_ALLOCATE;
    assign write_from_mem = dfp_read && dfp_resp;
    assign flush_done     = state == ST_FLUSH && !wb_needed && last_entry;

endmodule

`default_nettype wire

// ==== mutative_pkg.sv ====
`default_nettype none

package mutative_pkg;

    localparam int WAYS         = 4;    // physical ways
    localparam int SETS         = 8;    // sets per way
    localparam int LINE_BITS    = 128;
    localparam int OFFSET_BITS  = 4;    // byte offset in line
    localparam int SET_BITS     = 3;
    localparam int TAG_BITS     = 32 - OFFSET_BITS - SET_BITS;
    localparam int WAY_IDX_BITS = 2;

    // code 3 is handled as 4-way wherever setup is decoded
    typedef enum logic [1:0] {
        SETUP_DM   = 2'd0,
        SETUP_2WAY = 2'd1,
        SETUP_4WAY = 2'd2
    } setup_t;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_COMPARE   = 3'd1,
        ST_WRITEBACK = 3'd2,
        ST_ALLOCATE  = 3'd3,
        ST_FLUSH     = 3'd4,
        ST_FLUSH_WB  = 3'd5
    } cache_state_t;

    // apb register map
    localparam logic [3:0] REG_SETUP  = 4'h0;
    localparam logic [3:0] REG_HITS   = 4'h4;
    localparam logic [3:0] REG_MISSES = 4'h8;

endpackage

`default_nettype wire

// ==== mutative_plru.sv ====
`default_nettype none

module mutative_plru #(
    parameter int WAYS = mutative_pkg::WAYS,
    parameter int SETS = mutative_pkg::SETS
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  [mutative_pkg::SET_BITS-1:0]     set_index,
    input  wire  [1:0]                            tag_low,
    input  wire  mutative_pkg::setup_t            setup,
    input  wire  [mutative_pkg::WAY_IDX_BITS-1:0] access_way,
    input  wire                                   access_en,
    output logic [mutative_pkg::WAY_IDX_BITS-1:0] victim_way
);
    import mutative_pkg::*;

    logic [WAYS-2:0] tree [SETS];   // [0] root, [1] ways 0/1, [2] ways 2/3
    logic [WAYS-2:0] cur;

    assign cur = tree[set_index];

    // point each touched node away from the accessed way
    always_ff @(posedge clk) begin
        if (rst) begin
            tree <= '{default: '0};
        end else if (access_en) begin
            tree[set_index][0] <= ~access_way[1];
            if (access_way[1]) begin
                tree[set_index][2] <= ~access_way[0];
            end else begin
                tree[set_index][1] <= ~access_way[0];
            end
        end
    end

    always_comb begin
        case (setup)
            SETUP_DM:   victim_way = tag_low;
            SETUP_2WAY: victim_way = {tag_low[0], tag_low[0] ? cur[2] : cur[1]};
            default:    victim_way = {cur[0], cur[0] ? cur[2] : cur[1]};  // full walk
        endcase
    end

endmodule

`default_nettype wire

// ==== mutative_top.sv ====
`default_nettype none

module mutative_top #(
    parameter int WAYS = mutative_pkg::WAYS,
    parameter int SETS = mutative_pkg::SETS
) (
    input  wire          clk,
    input  wire          rst,
    input  wire  [31:0]  ufp_addr,
    input  wire  [3:0]   ufp_rmask,
    input  wire  [3:0]   ufp_wmask,
    input  wire  [31:0]  ufp_wdata,
    output logic [31:0]  ufp_rdata,
    output logic         ufp_resp,
    output logic [31:0]  dfp_addr,
    output logic         dfp_read,
    output logic         dfp_write,
    output logic [127:0] dfp_wdata,
    input  wire  [127:0] dfp_rdata,
    input  wire          dfp_resp,
    input  wire  [3:0]   paddr,
    input  wire          psel,
    input  wire          penable,
    input  wire          pwrite,
    input  wire  [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready
);
    import mutative_pkg::*;

    setup_t setup;          // current associativity
    logic   flush_req;
    logic   flush_done;
    logic   hit_pulse;
    logic   miss_pulse;

    mutative_cache #(.WAYS(WAYS), .SETS(SETS)) u_cache (
        .clk        (clk),
        .rst        (rst),
        .ufp_addr   (ufp_addr),
        .ufp_rmask  (ufp_rmask),
        .ufp_wmask  (ufp_wmask),
        .ufp_wdata  (ufp_wdata),
        .ufp_rdata  (ufp_rdata),
        .ufp_resp   (ufp_resp),
        .dfp_addr   (dfp_addr),
        .dfp_read   (dfp_read),
        .dfp_write  (dfp_write),
        .dfp_wdata  (dfp_wdata),
        .dfp_rdata  (dfp_rdata),
        .dfp_resp   (dfp_resp),
        .setup      (setup),
        .flush_req  (flush_req),
        .flush_done (flush_done),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse)
    );

    mutative_cfg_apb u_cfg (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .setup      (setup),
        .flush_req  (flush_req),
        .flush_done (flush_done),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse)
    );

endmodule

`default_nettype wire

// ==== mutative_trace.txt ====
# op addr data mask expect
# op 0 cpu read, 1 cpu write, 2 apb write, 3 apb read
0 00000100 00000000 f a5a5a4a5
0 00000104 00000000 f a5a5a4a1
3 00000004 00000000 0 00000001
3 00000008 00000000 0 00000001
1 00000108 11223344 3 00000000
0 00000108 00000000 f a5a53344
0 00000180 00000000 f a5a5a425
0 00000200 00000000 f a5a5a7a5
0 00000280 00000000 f a5a5a725
0 00000108 00000000 f a5a53344
0 00000300 00000000 f a5a5a6a5
0 00000184 00000000 f a5a5a421
0 00000100 00000000 f a5a5a4a5
0 00000280 00000000 f a5a5a725
3 00000004 00000000 0 00000006
3 00000008 00000000 0 00000006
2 00000000 00000000 0 00000000
3 00000000 00000000 0 00000000
0 00000108 00000000 f a5a53344
0 00000300 00000000 f a5a5a6a5
0 0000010c 00000000 f a5a5a4a9
3 00000008 00000000 0 00000009
2 00000000 00000001 0 00000000
1 00000100 deadbeef f 00000000
0 00000200 00000000 f a5a5a7a5
0 00000100 00000000 f deadbeef
0 00000300 00000000 f a5a5a6a5
0 00000100 00000000 f deadbeef
0 00000200 00000000 f a5a5a7a5
0 00000100 00000000 f deadbeef
3 00000004 00000000 0 00000009
2 00000004 00000000 0 00000000
3 00000004 00000000 0 00000000
3 00000008 00000000 0 0000000d

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_top -f list.f -o Vtb_top
out=$(./obj_dir/Vtb_top)
echo "$out"
echo "$out" | grep -qx "test passed"

// ==== tb_checker.sv ====
`default_nettype none

module tb_checker (
    input  wire        clk,
    input  wire        ufp_resp,
    input  wire [31:0] ufp_rdata,
    input  wire [3:0]  paddr,
    input  wire        psel,
    input  wire        penable,
    input  wire        pwrite,
    input  wire [31:0] pwdata,
    input  wire        pready,
    input  wire [31:0] prdata,
    input  wire        step_valid,
    input  wire [1:0]  step_op,     // 0 read, 1 write, 2 apb write, 3 apb read
    input  wire [31:0] step_exp,
    input  wire [31:0] step_num,
    input  wire        report,
    output int         error_count,
    output int         done_count
);
    timeunit 1ns;
    timeprecision 100ps;

    import mutative_pkg::*;

    logic       cpu_done;
    logic       apb_done;
    logic       waited;         // pready seen low in this transfer
    logic       stall_exp;
    logic [1:0] model_setup;    // setup after the last setup write

    assign cpu_done = step_op <= 2'd1 && ufp_resp;
    assign apb_done = step_op >= 2'd2 && psel && penable && pready;

    initial begin
        error_count = 0;
        done_count  = 0;
        waited      = 1'b0;
        model_setup = SETUP_4WAY;   // reset value
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h got %h",
                     $time, name, expected, actual);
            error_count++;
            $display("step %0d op %0d FAIL", step_num, step_op);
        end else begin
            $display("step %0d op %0d ok", step_num, step_op);
        end
    endtask

    // mid-cycle sampling, outputs settled
    always @(negedge clk) begin
        if (psel && penable && !pready) begin
            waited = 1'b1;
        end
        if (step_valid && (cpu_done || apb_done)) begin
            done_count++;
            case (step_op)
                2'd0:    compare_value("ufp_rdata", step_exp, ufp_rdata);
                2'd2: begin
                    // only a changed setup holds the transfer for the flush
                    stall_exp = pwrite && paddr == REG_SETUP && pwdata[1:0] != model_setup;
                    if (pwrite && paddr == REG_SETUP) model_setup = pwdata[1:0];
                    compare_value("pready wait", {31'd0, stall_exp}, {31'd0, waited});
                end
                2'd3:    compare_value("prdata", step_exp, prdata);
                default: $display("step %0d op %0d ok", step_num, step_op);
            endcase
            waited = 1'b0;
        end
    end

    always @(posedge report) begin
        $display("steps completed %0d, errors %0d", done_count, error_count);
    end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic         clk;
    logic         rst;
    logic [31:0]  ufp_addr;
    logic [3:0]   ufp_rmask;
    logic [3:0]   ufp_wmask;
    logic [31:0]  ufp_wdata;
    logic [31:0]  ufp_rdata;
    logic         ufp_resp;
    logic [31:0]  dfp_addr;
    logic         dfp_read;
    logic         dfp_write;
    logic [127:0] dfp_wdata;
    logic [127:0] dfp_rdata;
    logic         dfp_resp;
    logic [3:0]   paddr;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [31:0]  pwdata;
    logic [31:0]  prdata;
    logic         pready;
    logic         step_valid;
    logic [1:0]   step_op;
    logic [31:0]  step_exp;
    logic [31:0]  step_num;
    logic         report;
    logic         loaded;
    int           error_count;
    int           done_count;
    int           seed;
    logic [31:0]  t_op [$];     // trace columns
    logic [31:0]  t_addr [$];
    logic [31:0]  t_data [$];
    logic [31:0]  t_mask [$];
    logic [31:0]  t_exp [$];
    logic [127:0] mem [logic [27:0]];   // written-back lines

    mutative_top UUT (.*);

    tb_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [127:0] fill_line(input logic [31:0] addr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[32*w +: 32] = {addr[31:4], 4'(4*w)} ^ 32'hA5A5A5A5;
        end
        return line;
    endfunction

    // memory with random response delay
    initial begin
        seed      = 35767;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(posedge clk);
            #2;
            if (dfp_read || dfp_write) begin
                repeat (1 + ($random(seed) & 3)) @(posedge clk);
                #1;
                if (dfp_write) begin
                    mem[dfp_addr[31:4]] = dfp_wdata;
                end else if (mem.exists(dfp_addr[31:4])) begin
                    dfp_rdata = mem[dfp_addr[31:4]];
                end else begin
                    dfp_rdata = fill_line(dfp_addr);
                end
                dfp_resp = 1'b1;
                @(posedge clk);
                #1 dfp_resp = 1'b0;
            end
        end
    end

    task automatic load_trace();
        int    fd;
        int    n;
        string line;
        logic [31:0] op, addr, data, mask, exp_v;
        fd = $fopen("mutative_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file mutative_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 0) != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h", op, addr, data, mask, exp_v) == 5) begin
                        t_op.push_back(op);
                        t_addr.push_back(addr);
                        t_data.push_back(data);
                        t_mask.push_back(mask);
                        t_exp.push_back(exp_v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic cpu_access(input int i);
        ufp_addr  = t_addr[i];
        ufp_wdata = t_data[i];
        ufp_rmask = t_op[i] == 0 ? t_mask[i][3:0] : 4'h0;
        ufp_wmask = t_op[i] == 1 ? t_mask[i][3:0] : 4'h0;
        do @(negedge clk); while (!ufp_resp);
        @(posedge clk);
        #1;
        ufp_rmask = 4'h0;
        ufp_wmask = 4'h0;
    endtask

    task automatic apb_access(input int i);
        paddr   = t_addr[i][3:0];
        pwrite  = t_op[i] == 2;
        pwdata  = t_data[i];
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1 penable = 1'b1;
        do @(negedge clk); while (!pready);     // held low during a flush
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        loaded = 1'b0;
        wait (loaded);
        repeat (t_op.size() * 200) @(posedge clk);
        $display("watchdog expired, trace did not complete in time");
        $display("test failed");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        ufp_addr   = '0;
        ufp_rmask  = '0;
        ufp_wmask  = '0;
        ufp_wdata  = '0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        step_valid = 1'b0;
        step_op    = '0;
        step_exp   = '0;
        step_num   = '0;
        report     = 1'b0;
        load_trace();
        if (t_op.size() == 0) begin
            $display("no test steps were loaded from the trace file");
            $display("test failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (4) @(posedge clk);
            #1 rst = 1'b0;
            for (int i = 0; i < t_op.size(); i++) begin
                step_num   = i + 1;
                step_op    = t_op[i][1:0];
                step_exp   = t_exp[i];
                step_valid = 1'b1;
                if (t_op[i] <= 1) cpu_access(i);
                else apb_access(i);
                step_valid = 1'b0;
            end
            repeat (2) @(posedge clk);
            report = 1'b1;
            #1;
            if (error_count == 0 && done_count == t_op.size()) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
